//--- Makefile
# Verilator build and run of the SATA command layer testbench

VERILATOR ?= verilator
TOP       ?= tb_sata_command_layer
FILELIST  ?= sata_command_layer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(BIN)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/cl_control.sv
// Command layer control machine: settle timer, soft reset, status capture and busy flag
`timescale 1ns/1ps

module cl_control (
  input  logic        clk,
  input  logic        reset_timeout,
  input  logic        linkup,
  input  logic        transport_layer_ready,
  input  logic        send_user_command_stb,
  input  logic        command_layer_reset,
  input  logic        send_sync_escape,
  input  logic        t_d2h_reg_stb,
  input  logic        t_set_device_bits_stb,
  input  logic [7:0]  d2h_status,
  cl_seq_if.control   seq,
  output logic        user_cmd_stb,
  output logic        t_send_control_stb,
  output logic        srst,
  output logic        sata_busy,
  output logic        hard_drive_error,
  output logic        command_layer_ready
);
  import sata_fis_pkg::*;
  import cl_state_pkg::*;

  logic [1:0]  settle_count;
  logic        settle_done;
  logic        prev_user_cmd;
  ata_status_u status;

  // Holding command_layer_reset counts as a pending soft reset
  assign seq.idle = !seq.read_active && !seq.write_active &&
                    !command_layer_reset && transport_layer_ready;
  assign seq.abort = command_layer_reset || !settle_done || send_sync_escape;

  assign command_layer_ready = seq.idle && settle_done;
  assign hard_drive_error    = status.flags.err;

  always_ff @(posedge clk) begin
    if (!reset_timeout || !linkup) begin
      settle_count       <= '0;
      settle_done        <= 1'b0;
      prev_user_cmd      <= 1'b0;
      user_cmd_stb       <= 1'b0;
      t_send_control_stb <= 1'b0;
      srst               <= 1'b0;
      status.raw         <= '0;
      sata_busy          <= 1'b1;
    end else begin
      user_cmd_stb       <= 1'b0;
      t_send_control_stb <= 1'b0;

      if (settle_count < SETTLE_CYCLES) begin
        settle_count <= settle_count + 2'd1;
      end
      settle_done <= (settle_count == SETTLE_CYCLES);

      // Rising edge of the user command request
      prev_user_cmd <= send_user_command_stb;
      if (send_user_command_stb && !prev_user_cmd) begin
        user_cmd_stb <= 1'b1;
      end

      // Enter soft reset and restart the settle timer
      if (command_layer_reset && !srst) begin
        srst               <= 1'b1;
        t_send_control_stb <= 1'b1;
        settle_count       <= '0;
        settle_done        <= 1'b0;
      end else if (srst && seq.idle && settle_done) begin
        srst               <= 1'b0;
        t_send_control_stb <= 1'b1;
      end

      if (t_d2h_reg_stb || t_set_device_bits_stb) begin
        status.raw <= d2h_status;
      end

      // A running sequence counts as an outstanding command
      if (user_cmd_stb || t_send_control_stb || send_user_command_stb ||
          seq.read_active || seq.write_active) begin
        sata_busy <= 1'b1;
      end
      if (t_d2h_reg_stb || send_sync_escape) begin
        sata_busy <= 1'b0;
      end
    end
  end

  // Enter and leave of soft reset never fire back to back
  assert property (@(posedge clk) disable iff (!reset_timeout || !linkup)
    t_send_control_stb |=> !t_send_control_stb);

endmodule

//--- rtl/cl_h2d_regs.sv
// Host-to-device register values: command latch, LBA selection and control byte
`timescale 1ns/1ps

module cl_h2d_regs (
  input  logic        clk,
  input  logic        reset_timeout,
  input  logic        write_data_en,
  input  logic        read_data_en,
  input  logic        single_rdwr,
  input  logic        send_user_command_stb,
  input  logic [7:0]  hard_drive_command,
  input  logic [47:0] sector_address,
  input  logic [15:0] sector_count,
  input  logic [47:0] d2h_lba,
  input  logic        srst,
  cl_seq_if.regs      seq,
  output logic [7:0]  h2d_command,
  output logic [7:0]  h2d_control,
  output logic [7:0]  h2d_device,
  output logic [47:0] h2d_lba,
  output logic [15:0] h2d_sector_count
);
  import sata_fis_pkg::*;

  always_ff @(posedge clk) begin
    if (!reset_timeout) begin
      h2d_command <= '0;
    end else if (write_data_en) begin
      h2d_command <= CMD_DMA_WRITE_EX;
    end else if (read_data_en) begin
      h2d_command <= CMD_DMA_READ_EX;
    end else if (send_user_command_stb) begin
      h2d_command <= hard_drive_command;
    end
  end

  // Later blocks of a multi-block transfer continue after the device's last LBA
  always_comb begin
    h2d_lba = sector_address;
    if (write_data_en) begin
      if (!single_rdwr && !seq.first_write) begin
        h2d_lba = d2h_lba + 48'd1;
      end
    end else if (read_data_en) begin
      if (!single_rdwr && !seq.first_read) begin
        h2d_lba = d2h_lba + 48'd1;
      end
    end
  end

  always_comb begin
    h2d_control           = '0;
    h2d_control[SRST_BIT] = srst;
  end

  assign h2d_device       = DEVICE_LBA;
  assign h2d_sector_count = sector_count;

endmodule

//--- rtl/cl_read_seq.sv
// DMA read sequencer with sync escape generation
`timescale 1ns/1ps

module cl_read_seq (
  input  logic        clk,
  input  logic        reset_timeout,
  input  logic        linkup,
  input  logic        read_data_en,
  input  logic        single_rdwr,
  input  logic        send_sync_escape,
  input  logic        command_layer_reset,
  input  logic        t_d2h_reg_stb,
  cl_seq_if.read_seq  seq,
  output logic        read_cmd_stb,
  output logic        sync_escape
);
  import cl_state_pkg::*;

  read_state_e state;
  logic        single_prev;
  logic        first_read;

  assign seq.read_active = (state != RD_IDLE);
  assign seq.first_read  = first_read;

  always_ff @(posedge clk) begin
    if (!reset_timeout || !linkup) begin
      state        <= RD_IDLE;
      read_cmd_stb <= 1'b0;
      sync_escape  <= 1'b0;
      single_prev  <= 1'b0;
      first_read   <= 1'b1;
    end else begin
      read_cmd_stb <= 1'b0;
      sync_escape  <= 1'b0;

      if (!read_data_en) begin
        single_prev <= 1'b0;
      end

      case (state)
        RD_IDLE: begin
          if (!read_data_en) begin
            first_read <= 1'b1;
          end else if (seq.idle && !seq.abort && (!single_rdwr || !single_prev)) begin
            // Single mode issues one command per assertion of read_data_en
            single_prev  <= 1'b1;
            read_cmd_stb <= 1'b1;
            state        <= RD_WAIT_DATA;
          end
        end
        RD_WAIT_DATA: begin
          if (t_d2h_reg_stb) begin
            first_read <= 1'b0;
            state      <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase

      if (seq.abort) begin
        state <= RD_IDLE;
      end

      // Cancel an open read on soft reset
      if (send_sync_escape || (command_layer_reset && state != RD_IDLE)) begin
        sync_escape <= 1'b1;
      end
    end
  end

  // Read commands start from RD_IDLE and never during soft reset or sync escape
  assert property (@(posedge clk) disable iff (!reset_timeout || !linkup)
    read_cmd_stb |-> $past(state == RD_IDLE && !command_layer_reset && !send_sync_escape));

endmodule

//--- rtl/cl_seq_if.sv
// Command layer internal bus between control machine, sequencers and register block
`timescale 1ns/1ps

interface cl_seq_if;

  // From the control machine
  logic idle;
  logic abort;

  // From the sequencers
  logic read_active;
  logic first_read;
  logic write_active;
  logic first_write;

  modport control (output idle, abort, input read_active, write_active);

  modport read_seq (input idle, abort, output read_active, first_read);

  modport write_seq (input idle, abort, output write_active, first_write);

  modport regs (input first_read, first_write);

endinterface

//--- rtl/cl_state_pkg.sv
// Command layer state encodings and settle timing
package cl_state_pkg;

  // Read sequencer
  typedef enum logic [1:0] {
    RD_IDLE      = 2'd0,
    RD_WAIT_DATA = 2'd1
  } read_state_e;

  // Write sequencer, one data frame per DMA activate
  typedef enum logic [1:0] {
    WR_IDLE         = 2'd0,
    WR_WAIT_DMA_ACT = 2'd1,
    WR_WAIT_DATA    = 2'd2,
    WR_SEND_DATA    = 2'd3
  } write_state_e;

  // Cycles to wait after reset or soft reset before accepting commands
  localparam logic [1:0] SETTLE_CYCLES = 2'd2;

endpackage

//--- rtl/cl_write_seq.sv
// DMA write sequencer with DMA activate handshake and data frame strobes
`timescale 1ns/1ps

module cl_write_seq (
  input  logic        clk,
  input  logic        reset_timeout,
  input  logic        linkup,
  input  logic        write_data_en,
  input  logic        single_rdwr,
  input  logic        transport_layer_ready,
  input  logic        t_dma_activate_stb,
  input  logic        t_if_activate,
  input  logic        t_d2h_reg_stb,
  cl_seq_if.write_seq seq,
  output logic        write_cmd_stb,
  output logic        t_send_data_stb,
  output logic        t_if_ready
);
  import cl_state_pkg::*;

  write_state_e state;
  logic         single_prev;
  logic         first_write;
  logic         dma_act_seen;
  logic         data_ready_en;

  assign seq.write_active = (state != WR_IDLE);
  assign seq.first_write  = first_write;
  assign t_if_ready       = data_ready_en;

  always_ff @(posedge clk) begin
    if (!reset_timeout || !linkup) begin
      state           <= WR_IDLE;
      write_cmd_stb   <= 1'b0;
      t_send_data_stb <= 1'b0;
      single_prev     <= 1'b0;
      first_write     <= 1'b1;
      dma_act_seen    <= 1'b0;
      data_ready_en   <= 1'b0;
    end else begin
      write_cmd_stb   <= 1'b0;
      t_send_data_stb <= 1'b0;

      // Transport took the data phase
      if (data_ready_en && t_if_activate) begin
        data_ready_en <= 1'b0;
      end

      if (!write_data_en) begin
        single_prev <= 1'b0;
      end

      // Keep the DMA activate pulse until the FSM gets to it
      if (t_dma_activate_stb) begin
        dma_act_seen <= 1'b1;
      end

      case (state)
        WR_IDLE: begin
          dma_act_seen <= 1'b0;
          if (!write_data_en) begin
            first_write <= 1'b1;
          end else if (seq.idle && !seq.abort && (!single_rdwr || !single_prev)) begin
            single_prev   <= 1'b1;
            write_cmd_stb <= 1'b1;
            state         <= WR_WAIT_DMA_ACT;
          end
        end
        WR_WAIT_DMA_ACT: begin
          if (dma_act_seen) begin
            dma_act_seen  <= 1'b0;
            first_write   <= 1'b0;
            data_ready_en <= 1'b1;
            state         <= WR_WAIT_DATA;
          end
        end
        WR_WAIT_DATA: begin
          if (t_if_activate) begin
            state <= WR_SEND_DATA;
          end
        end
        WR_SEND_DATA: begin
          // Data FIS goes out once the transport can take it
          if (transport_layer_ready) begin
            t_send_data_stb <= 1'b1;
            state           <= WR_WAIT_DMA_ACT;
          end
        end
        default: state <= WR_IDLE;
      endcase

      if (seq.abort || t_d2h_reg_stb) begin
        state         <= WR_IDLE;
        data_ready_en <= 1'b0;
      end
    end
  end

  // Data frames need a ready transport and a data phase already taken
  assert property (@(posedge clk) disable iff (!reset_timeout || !linkup)
    t_send_data_stb |-> $past(transport_layer_ready && !data_ready_en));

endmodule

//--- rtl/sata_command_layer.sv
// SATA host command layer top: control machine, DMA sequencers and H2D registers
`timescale 1ns/1ps

module sata_command_layer (
  input  logic        clk,
  input  logic        reset_timeout,
  input  logic        linkup,
  input  logic        transport_layer_ready,
  input  logic        send_user_command_stb,
  input  logic        command_layer_reset,
  input  logic        send_sync_escape,
  input  logic        read_data_en,
  input  logic        write_data_en,
  input  logic        single_rdwr,
  input  logic        t_d2h_reg_stb,
  input  logic        t_set_device_bits_stb,
  input  logic        t_dma_activate_stb,
  input  logic        t_if_activate,
  input  logic [7:0]  hard_drive_command,
  input  logic [7:0]  d2h_status,
  input  logic [15:0] sector_count,
  input  logic [47:0] sector_address,
  input  logic [47:0] d2h_lba,
  output logic        command_layer_ready,
  output logic        sata_busy,
  output logic        hard_drive_error,
  output logic        sync_escape,
  output logic        t_send_command_stb,
  output logic        t_send_control_stb,
  output logic        t_send_data_stb,
  output logic        t_if_ready,
  output logic [7:0]  h2d_command,
  output logic [7:0]  h2d_control,
  output logic [7:0]  h2d_device,
  output logic [47:0] h2d_lba,
  output logic [15:0] h2d_sector_count
);

  logic user_cmd_stb;
  logic read_cmd_stb;
  logic write_cmd_stb;
  logic srst;

  cl_seq_if seq_if ();

  // One command FIS strobe for user, read and write requests
  assign t_send_command_stb = user_cmd_stb | read_cmd_stb | write_cmd_stb;

  cl_control u_control (
    .clk                   (clk),
    .reset_timeout         (reset_timeout),
    .linkup                (linkup),
    .transport_layer_ready (transport_layer_ready),
    .send_user_command_stb (send_user_command_stb),
    .command_layer_reset   (command_layer_reset),
    .send_sync_escape      (send_sync_escape),
    .t_d2h_reg_stb         (t_d2h_reg_stb),
    .t_set_device_bits_stb (t_set_device_bits_stb),
    .d2h_status            (d2h_status),
    .seq                   (seq_if.control),
    .user_cmd_stb          (user_cmd_stb),
    .t_send_control_stb    (t_send_control_stb),
    .srst                  (srst),
    .sata_busy             (sata_busy),
    .hard_drive_error      (hard_drive_error),
    .command_layer_ready   (command_layer_ready)
  );

  cl_read_seq u_read_seq (
    .clk                 (clk),
    .reset_timeout       (reset_timeout),
    .linkup              (linkup),
    .read_data_en        (read_data_en),
    .single_rdwr         (single_rdwr),
    .send_sync_escape    (send_sync_escape),
    .command_layer_reset (command_layer_reset),
    .t_d2h_reg_stb       (t_d2h_reg_stb),
    .seq                 (seq_if.read_seq),
    .read_cmd_stb        (read_cmd_stb),
    .sync_escape         (sync_escape)
  );

  cl_write_seq u_write_seq (
    .clk                   (clk),
    .reset_timeout         (reset_timeout),
    .linkup                (linkup),
    .write_data_en         (write_data_en),
    .single_rdwr           (single_rdwr),
    .transport_layer_ready (transport_layer_ready),
    .t_dma_activate_stb    (t_dma_activate_stb),
    .t_if_activate         (t_if_activate),
    .t_d2h_reg_stb         (t_d2h_reg_stb),
    .seq                   (seq_if.write_seq),
    .write_cmd_stb         (write_cmd_stb),
    .t_send_data_stb       (t_send_data_stb),
    .t_if_ready            (t_if_ready)
  );

  cl_h2d_regs u_h2d_regs (
    .clk                   (clk),
    .reset_timeout         (reset_timeout),
    .write_data_en         (write_data_en),
    .read_data_en          (read_data_en),
    .single_rdwr           (single_rdwr),
    .send_user_command_stb (send_user_command_stb),
    .hard_drive_command    (hard_drive_command),
    .sector_address        (sector_address),
    .sector_count          (sector_count),
    .d2h_lba               (d2h_lba),
    .srst                  (srst),
    .seq                   (seq_if.regs),
    .h2d_command           (h2d_command),
    .h2d_control           (h2d_control),
    .h2d_device            (h2d_device),
    .h2d_lba               (h2d_lba),
    .h2d_sector_count      (h2d_sector_count)
  );

endmodule

//--- rtl/sata_fis_pkg.sv
// SATA FIS definitions: ATA command codes, register values and the status byte layout
package sata_fis_pkg;

  // ATA commands used by the DMA sequencers
  localparam logic [7:0] CMD_DMA_READ_EX  = 8'h25;
  localparam logic [7:0] CMD_DMA_WRITE_EX = 8'h35;

  // Device register with the LBA mode bit set
  localparam logic [7:0] DEVICE_LBA = 8'h40;

  // Soft reset bit of the device control register
  localparam int SRST_BIT = 2;

  // ATA status flags, MSB first
  typedef struct packed {
    logic busy;
    logic drdy;
    logic df;
    logic dsc;
    logic drq;
    logic corr;
    logic idx;
    logic err;
  } ata_status_s;

  typedef union packed {
    logic [7:0]  raw;
    ata_status_s flags;
  } ata_status_u;

endpackage

//--- sata_command_layer.f
rtl/sata_fis_pkg.sv
rtl/cl_state_pkg.sv
rtl/cl_seq_if.sv
rtl/cl_control.sv
rtl/cl_read_seq.sv
rtl/cl_write_seq.sv
rtl/cl_h2d_regs.sv
rtl/sata_command_layer.sv
sim/tb_clock.sv
sim/tb_sata_command_layer.sv

//--- sim/tb_clock.sv
// Testbench clock source with a 20 ns period
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  localparam int HALF_PERIOD_NS = 10;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

endmodule

//--- sim/tb_sata_command_layer.sv
// Table-driven testbench for the SATA command layer with a simple device model
`timescale 1ns/1ps

module tb_sata_command_layer;
  import sata_fis_pkg::*;

  typedef enum int {OP_USER, OP_READ, OP_WRITE, OP_SRST, OP_ESCAPE} op_e;

  typedef struct {
    string       name;
    op_e         op;
    logic        single;
    logic [7:0]  command;
    logic [47:0] address;
    logic [47:0] dev_lba;
    logic [7:0]  status;
    logic [7:0]  exp_cmd;
    logic [47:0] exp_lba;
    logic [47:0] exp_next_lba;
    int          exp_stb;
  } test_row_t;

  localparam int          NUM_TESTS    = 7;
  localparam int          ROW_CYCLES   = 200;
  localparam int          RESET_CYCLES = 5;
  localparam logic [31:0] RAND_SEED    = 32'hbfca;
  // Two settle cycles plus the registered done flag
  localparam int          READY_EDGES  = 3;
  localparam logic [15:0] SECTOR_COUNT = 16'h0008;
  // LBA mode device register
  localparam logic [7:0]  EXP_DEVICE   = 8'h40;

  logic        clk;
  logic        reset_timeout;
  logic        linkup;
  logic        transport_layer_ready;
  logic        send_user_command_stb;
  logic        command_layer_reset;
  logic        send_sync_escape;
  logic        read_data_en;
  logic        write_data_en;
  logic        single_rdwr;
  logic        t_d2h_reg_stb;
  logic        t_set_device_bits_stb;
  logic        t_dma_activate_stb;
  logic        t_if_activate;
  logic [7:0]  hard_drive_command;
  logic [7:0]  d2h_status;
  logic [15:0] sector_count;
  logic [47:0] sector_address;
  logic [47:0] d2h_lba;
  logic        command_layer_ready;
  logic        sata_busy;
  logic        hard_drive_error;
  logic        sync_escape;
  logic        t_send_command_stb;
  logic        t_send_control_stb;
  logic        t_send_data_stb;
  logic        t_if_ready;
  logic [7:0]  h2d_command;
  logic [7:0]  h2d_control;
  logic [7:0]  h2d_device;
  logic [47:0] h2d_lba;
  logic [15:0] h2d_sector_count;

  test_row_t tests [NUM_TESTS];
  int        cmd_count = 0;
  int        ctrl_count = 0;
  int        data_count = 0;
  int        esc_count = 0;

  tb_clock clock_gen (.clk(clk));

  sata_command_layer dut (.*);

  // Strobe counters see each pulse at the rising edge after it appears
  always @(posedge clk) begin
    if (t_send_command_stb) cmd_count <= cmd_count + 1;
    if (t_send_control_stb) ctrl_count <= ctrl_count + 1;
    if (t_send_data_stb) data_count <= data_count + 1;
    if (sync_escape) esc_count <= esc_count + 1;
  end

  // Watchdog over the whole table plus the reset phase
  initial begin
    repeat ((NUM_TESTS + 1) * ROW_CYCLES) @(posedge clk);
    $display("Test FAILED");
    $fatal(1, "Timeout: the test table did not finish within %0d cycles",
           (NUM_TESTS + 1) * ROW_CYCLES);
  end

  task automatic check_value(input string test, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s (%s): expected 0x%0h, actual 0x%0h",
               test, what, expected, actual);
      $display("Test FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic set_row(input int idx, input string name, input op_e op, input logic single,
                         input logic [7:0] command, input logic [47:0] address,
                         input logic [47:0] dev_lba, input logic [7:0] status,
                         input logic [7:0] exp_cmd, input logic [47:0] exp_lba,
                         input logic [47:0] exp_next_lba, input int exp_stb);
    tests[idx] = '{name, op, single, command, address, dev_lba, status,
                   exp_cmd, exp_lba, exp_next_lba, exp_stb};
  endtask

  // Device model answers after 1 to 4 cycles
  task automatic device_delay();
    repeat ($urandom_range(4, 1)) @(negedge clk);
  endtask

  task automatic send_dma_activate();
    device_delay();
    t_dma_activate_stb = 1'b1;
    @(negedge clk);
    t_dma_activate_stb = 1'b0;
  endtask

  task automatic send_reg_fis(input logic [7:0] status);
    device_delay();
    d2h_status    = status;
    t_d2h_reg_stb = 1'b1;
    @(negedge clk);
    t_d2h_reg_stb = 1'b0;
  endtask

  task automatic run_user(input test_row_t row);
    int start;
    start = cmd_count;
    hard_drive_command    = row.command;
    send_user_command_stb = 1'b1;
    repeat (2) @(negedge clk);
    send_user_command_stb = 1'b0;
    repeat (2) @(negedge clk);
    check_value(row.name, "h2d_command", 64'(row.exp_cmd), 64'(h2d_command));
    check_value(row.name, "command strobes", 64'(row.exp_stb), 64'(cmd_count - start));
  endtask

  task automatic run_read(input test_row_t row);
    int          start;
    ata_status_u exp_status;
    start = cmd_count;
    exp_status.raw = row.status;
    single_rdwr    = row.single;
    sector_address = row.address;
    d2h_lba        = row.dev_lba;
    read_data_en   = 1'b1;
    while (cmd_count == start) @(negedge clk);
    check_value(row.name, "h2d_command", 64'(row.exp_cmd), 64'(h2d_command));
    check_value(row.name, "h2d_lba", 64'(row.exp_lba), 64'(h2d_lba));
    send_reg_fis(row.status);
    check_value(row.name, "next h2d_lba", 64'(row.exp_next_lba), 64'(h2d_lba));
    // Multi mode starts the next block on this edge
    @(negedge clk);
    read_data_en = 1'b0;
    send_reg_fis(row.status);
    repeat (2) @(negedge clk);
    check_value(row.name, "command strobes", 64'(row.exp_stb), 64'(cmd_count - start));
    check_value(row.name, "hard_drive_error", 64'(exp_status.flags.err),
                64'(hard_drive_error));
  endtask

  task automatic run_write(input test_row_t row);
    int          start;
    int          data_start;
    ata_status_u exp_status;
    start = cmd_count;
    data_start = data_count;
    exp_status.raw = row.status;
    single_rdwr    = row.single;
    sector_address = row.address;
    d2h_lba        = row.dev_lba;
    write_data_en  = 1'b1;
    while (cmd_count == start) @(negedge clk);
    check_value(row.name, "h2d_command", 64'(row.exp_cmd), 64'(h2d_command));
    check_value(row.name, "h2d_lba", 64'(row.exp_lba), 64'(h2d_lba));
    send_dma_activate();
    while (!t_if_ready) @(negedge clk);
    // Transport takes the data phase while it is still busy
    transport_layer_ready = 1'b0;
    t_if_activate         = 1'b1;
    @(negedge clk);
    t_if_activate = 1'b0;
    check_value(row.name, "t_if_ready after activate", 64'd0, 64'(t_if_ready));
    repeat (4) @(negedge clk);
    check_value(row.name, "data strobes while busy", 64'd0, 64'(data_count - data_start));
    transport_layer_ready = 1'b1;
    repeat (2) @(negedge clk);
    check_value(row.name, "data strobes", 64'd1, 64'(data_count - data_start));
    send_reg_fis(row.status);
    write_data_en = 1'b0;
    repeat (2) @(negedge clk);
    check_value(row.name, "command strobes", 64'(row.exp_stb), 64'(cmd_count - start));
    check_value(row.name, "hard_drive_error", 64'(exp_status.flags.err),
                64'(hard_drive_error));
  endtask

  task automatic run_soft_reset(input test_row_t row);
    int start;
    start = ctrl_count;
    command_layer_reset = 1'b1;
    @(negedge clk);
    check_value(row.name, "h2d_control set", 64'(8'h01 << SRST_BIT), 64'(h2d_control));
    // Held long enough for the settle count, so release clears srst at the next edge
    repeat (3) @(negedge clk);
    command_layer_reset = 1'b0;
    @(negedge clk);
    check_value(row.name, "h2d_control cleared", 64'd0, 64'(h2d_control));
    @(negedge clk);
    check_value(row.name, "control strobes", 64'(row.exp_stb), 64'(ctrl_count - start));
  endtask

  task automatic run_escape(input test_row_t row);
    int start;
    int esc_start;
    start = cmd_count;
    esc_start = esc_count;
    single_rdwr    = row.single;
    sector_address = row.address;
    d2h_lba        = row.dev_lba;
    read_data_en   = 1'b1;
    while (cmd_count == start) @(negedge clk);
    check_value(row.name, "h2d_command", 64'(row.exp_cmd), 64'(h2d_command));
    check_value(row.name, "h2d_lba", 64'(row.exp_lba), 64'(h2d_lba));
    check_value(row.name, "sata_busy during read", 64'd1, 64'(sata_busy));
    send_sync_escape = 1'b1;
    @(negedge clk);
    send_sync_escape = 1'b0;
    @(negedge clk);
    check_value(row.name, "sata_busy after escape", 64'd0, 64'(sata_busy));
    read_data_en = 1'b0;
    repeat (2) @(negedge clk);
    check_value(row.name, "sync_escape pulses", 64'(row.exp_stb), 64'(esc_count - esc_start));
  endtask

  initial begin
    int settle_edges;
    void'($urandom(RAND_SEED));
    set_row(0, "user_identify", OP_USER, 1'b0, 8'hEC, 48'h0, 48'h0, 8'h00,
            8'hEC, 48'h0, 48'h0, 1);
    set_row(1, "read_multi", OP_READ, 1'b0, 8'h00, 48'h0000_0000_1000, 48'h0000_FFFF_FFFF,
            8'h50, 8'h25, 48'h0000_0000_1000, 48'h0001_0000_0000, 2);
    set_row(2, "read_single_err", OP_READ, 1'b1, 8'h00, 48'h0000_0000_2000,
            48'h0000_0000_2FFF, 8'h51, 8'h25, 48'h0000_0000_2000, 48'h0000_0000_2000, 1);
    set_row(3, "write_single", OP_WRITE, 1'b1, 8'h00, 48'h0000_0000_3000, 48'h0,
            8'h50, 8'h35, 48'h0000_0000_3000, 48'h0000_0000_3000, 1);
    set_row(4, "soft_reset", OP_SRST, 1'b0, 8'h00, 48'h0, 48'h0, 8'h00,
            8'h35, 48'h0, 48'h0, 2);
    set_row(5, "sync_escape", OP_ESCAPE, 1'b1, 8'h00, 48'h0000_0000_4000, 48'h0,
            8'h00, 8'h25, 48'h0000_0000_4000, 48'h0000_0000_4000, 1);
    set_row(6, "user_flush", OP_USER, 1'b0, 8'hEA, 48'h0, 48'h0, 8'h00,
            8'hEA, 48'h0, 48'h0, 1);

    reset_timeout         = 1'b0;
    linkup                = 1'b1;
    transport_layer_ready = 1'b1;
    send_user_command_stb = 1'b0;
    command_layer_reset   = 1'b0;
    send_sync_escape      = 1'b0;
    read_data_en          = 1'b0;
    write_data_en         = 1'b0;
    single_rdwr           = 1'b0;
    t_d2h_reg_stb         = 1'b0;
    t_set_device_bits_stb = 1'b0;
    t_dma_activate_stb    = 1'b0;
    t_if_activate         = 1'b0;
    hard_drive_command    = 8'h00;
    d2h_status            = 8'h00;
    sector_count          = SECTOR_COUNT;
    sector_address        = 48'h0;
    d2h_lba               = 48'h0;

    repeat (RESET_CYCLES) @(negedge clk);
    check_value("reset", "sata_busy", 64'd1, 64'(sata_busy));
    check_value("reset", "h2d_command", 64'd0, 64'(h2d_command));
    reset_timeout = 1'b1;
    settle_edges  = 0;
    do begin
      @(negedge clk);
      settle_edges++;
    end while (!command_layer_ready);
    check_value("reset", "edges to ready", 64'(READY_EDGES), 64'(settle_edges));
    check_value("reset", "h2d_device", 64'(EXP_DEVICE), 64'(h2d_device));
    check_value("reset", "h2d_sector_count", 64'(SECTOR_COUNT), 64'(h2d_sector_count));

    for (int i = 0; i < NUM_TESTS; i++) begin
      while (!command_layer_ready) @(negedge clk);
      case (tests[i].op)
        OP_USER:   run_user(tests[i]);
        OP_READ:   run_read(tests[i]);
        OP_WRITE:  run_write(tests[i]);
        OP_SRST:   run_soft_reset(tests[i]);
        OP_ESCAPE: run_escape(tests[i]);
      endcase
    end

    $display("Test OK");
    $finish;
  end

endmodule
